// ==== hw/lsu_pkg.sv ====
package lsu_pkg;

  localparam int XLEN    = 64;
  localparam int REG_IDX = 5;

  // register-width value as seen by the core
  typedef logic [XLEN-1:0]    xlen_t;
  typedef logic [REG_IDX-1:0] reg_idx_t;
  typedef logic [2:0]         funct3_t;

  typedef enum logic [1:0] {
    LSU_NONE  = 2'd0,
    LSU_LOAD  = 2'd1,
    LSU_STORE = 2'd2
  } lsu_op_e;

  // the low two bits of funct3 give the access size for loads and stores
  localparam funct3_t F3_B  = 3'b000;
  localparam funct3_t F3_H  = 3'b001;
  localparam funct3_t F3_W  = 3'b010;
  localparam funct3_t F3_D  = 3'b011;
  localparam funct3_t F3_BU = 3'b100;
  localparam funct3_t F3_HU = 3'b101;
  localparam funct3_t F3_WU = 3'b110;

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

  localparam int BUS_ADDR_W = 32;
  localparam int BUS_DATA_W = 64;
  localparam int BUS_STRB_W = BUS_DATA_W / 8;

  // the low three bits of a byte address pick the lane inside a beat
  typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

  // byte lane n of a beat sits at bits 8n+7 down to 8n
  typedef logic [BUS_DATA_W-1:0] bus_data_t;

  typedef logic [BUS_STRB_W-1:0] bus_strb_t;

endpackage

// ==== hw/mem_req_if.sv ====
`timescale 1ns/10ps

interface mem_req_if
  import lsu_pkg::*, bus_pkg::*;
();

  logic      req_valid;
  lsu_op_e   op;
  funct3_t   funct3;
  reg_idx_t  rd;
  bus_addr_t addr;
  bus_data_t wdata;
  bus_strb_t wstrb;
  logic      accept;

  // the entry moves on an edge where req_valid and accept are both high
  modport issue (
    output req_valid, op, funct3, rd, addr, wdata, wstrb,
    input  accept
  );

  modport access (
    input  req_valid, op, funct3, rd, addr, wdata, wstrb,
    output accept
  );

endinterface

// ==== hw/mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if
  import bus_pkg::*;
();

  logic      r_valid;
  bus_addr_t r_addr;
  logic      r_ready;
  logic      r_last;
  bus_data_t r_data;

  logic      w_valid;
  bus_addr_t w_addr;
  bus_data_t w_data;
  bus_strb_t w_strb;
  logic      w_ready;
  logic      w_last;

  modport master (
    output r_valid, r_addr, w_valid, w_addr, w_data, w_strb,
    input  r_ready, r_last, r_data, w_ready, w_last
  );

  modport slave (
    input  r_valid, r_addr, w_valid, w_addr, w_data, w_strb,
    output r_ready, r_last, r_data, w_ready, w_last
  );

endinterface

// ==== hw/lsu_issue.sv ====
`timescale 1ns/10ps

module lsu_issue
  import lsu_pkg::*, bus_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  lsu_op_e  op_i,
  input  funct3_t  funct3_i,
  input  xlen_t    src1_i,
  input  xlen_t    src2_i,
  input  xlen_t    imm_i,
  input  reg_idx_t rd_i,
  output logic     stall_o,
  mem_req_if.issue req
);

  xlen_t      eff_addr;
  bus_addr_t  addr;
  bus_strb_t  size_strb;
  logic [2:0] size_mask;
  logic       take;

  assign eff_addr = src1_i + imm_i;
  assign addr     = bus_addr_t'(eff_addr);

  // strobe for the access size before it is moved to the addressed lane
  always_comb begin
    case (funct3_i[1:0])
      2'b00:   size_strb = 8'h01;
      2'b01:   size_strb = 8'h03;
      2'b10:   size_strb = 8'h0f;
      default: size_strb = 8'hff;
    endcase
  end

  // the entry waits while access is busy, so the core has to hold its inputs
  assign stall_o = req.req_valid & ~req.accept;
  assign take    = ~stall_o & (op_i != LSU_NONE);

  always_ff @(posedge clk) begin
    if (reset) begin
      req.req_valid <= 1'b0;
    end else if (!stall_o) begin
      req.req_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      req.op     <= op_i;
      req.funct3 <= funct3_i;
      req.rd     <= rd_i;
      req.addr   <= addr;
      req.wdata  <= src2_i << {addr[2:0], 3'b000};
      if (op_i == LSU_STORE) begin
        req.wstrb <= bus_strb_t'(size_strb << addr[2:0]);
      end else begin
        req.wstrb <= '0;
      end
    end
  end

  // low address bits that must be zero for the held access size
  always_comb begin
    case (req.funct3[1:0])
      2'b00:   size_mask = 3'b000;
      2'b01:   size_mask = 3'b001;
      2'b10:   size_mask = 3'b011;
      default: size_mask = 3'b111;
    endcase
  end

  // misaligned accesses are not split in hardware
  a_aligned: assert property (@(posedge clk) disable iff (reset)
    (req.req_valid && req.accept) |-> ((req.addr[2:0] & size_mask) == 3'b000))
    else $error("misaligned access accepted at address %h", req.addr);

endmodule

// ==== hw/lsu_access.sv ====
`timescale 1ns/10ps

module lsu_access
  import lsu_pkg::*, bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  mem_req_if.access  req,
  mem_bus_if.master  bus,
  output logic       done_o,
  output reg_idx_t   done_rd_o,
  output funct3_t    done_funct3_o,
  output logic [2:0] done_lane_o,
  output bus_data_t  done_rdata_o,
  output logic       done_load_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_e;

  state_e    state;
  reg_idx_t  rd_q;
  funct3_t   funct3_q;
  bus_addr_t addr_q;
  bus_data_t wdata_q;
  bus_strb_t wstrb_q;
  logic      xfer_done;
  logic      take;

  // ready together with last closes the single beat on either channel
  assign xfer_done = (bus.r_valid & bus.r_ready & bus.r_last) |
                     (bus.w_valid & bus.w_ready & bus.w_last);

  // a finishing transfer frees the stage on the same edge
  assign req.accept = (state == ST_IDLE) | xfer_done;
  assign take       = req.req_valid & req.accept;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
    end else if (take) begin
      state <= (req.op == LSU_LOAD) ? ST_READ : ST_WRITE;
    end else if (xfer_done) begin
      state <= ST_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      rd_q     <= req.rd;
      funct3_q <= req.funct3;
      addr_q   <= req.addr;
      wdata_q  <= req.wdata;
      wstrb_q  <= req.wstrb;
    end
  end

  assign bus.r_valid = (state == ST_READ);
  assign bus.r_addr  = addr_q;
  assign bus.w_valid = (state == ST_WRITE);
  assign bus.w_addr  = addr_q;
  assign bus.w_data  = wdata_q;
  assign bus.w_strb  = wstrb_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      done_o <= 1'b0;
    end else begin
      done_o <= xfer_done;
    end
  end

  // the read beat is only valid during the ready pulse, so it is caught here
  always_ff @(posedge clk) begin
    if (xfer_done) begin
      done_rd_o     <= rd_q;
      done_funct3_o <= funct3_q;
      done_lane_o   <= addr_q[2:0];
      done_rdata_o  <= bus.r_data;
      done_load_o   <= (state == ST_READ);
    end
  end

  a_ready_needs_valid: assert property (@(posedge clk) disable iff (reset)
    (bus.r_ready |-> bus.r_valid) and (bus.w_ready |-> bus.w_valid))
    else $error("memory ready seen without a pending request");

  a_addr_stable: assert property (@(posedge clk) disable iff (reset)
    ((bus.r_valid || bus.w_valid) && !xfer_done) |=>
      ($stable(bus.r_addr) && $stable(bus.w_addr)))
    else $error("bus address changed while the request was pending");

endmodule

// ==== hw/lsu_align.sv ====
`timescale 1ns/10ps

module lsu_align
  import lsu_pkg::*, bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       done_i,
  input  reg_idx_t   rd_i,
  input  funct3_t    funct3_i,
  input  logic [2:0] lane_i,
  input  bus_data_t  rdata_i,
  input  logic       load_i,
  output logic       rd_wen_o,
  output reg_idx_t   rd_o,
  output xlen_t      rd_data_o
);

  bus_data_t shifted;
  xlen_t     result;

  // bring the addressed lane down to bit 0
  assign shifted = rdata_i >> {lane_i, 3'b000};

  always_comb begin
    case (funct3_i)
      F3_B:    result = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
      F3_H:    result = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
      F3_W:    result = {{(XLEN-32){shifted[31]}}, shifted[31:0]};
      F3_D:    result = shifted;
      F3_BU:   result = {{(XLEN-8){1'b0}}, shifted[7:0]};
      F3_HU:   result = {{(XLEN-16){1'b0}}, shifted[15:0]};
      F3_WU:   result = {{(XLEN-32){1'b0}}, shifted[31:0]};
      default: result = '0;
    endcase
  end

  // stores finish here too but never write the register file
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_wen_o <= 1'b0;
    end else begin
      rd_wen_o <= done_i & load_i;
    end
  end

  always_ff @(posedge clk) begin
    if (done_i && load_i) begin
      rd_o      <= rd_i;
      rd_data_o <= result;
    end
  end

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/10ps

module data_ram
  import bus_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic     clk,
  input  logic     reset,
  mem_bus_if.slave bus
);

  localparam int IDX_W = $clog2(RAM_WORDS);
  localparam int CNT_W = $clog2(RAM_LATENCY + 1);

  bus_data_t        mem [RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic             busy;
  logic             hit;
  logic [IDX_W-1:0] r_idx;
  logic [IDX_W-1:0] w_idx;

  initial begin
    for (int i = 0; i < RAM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign busy = bus.r_valid | bus.w_valid;

  // the last waiting cycle of a request is the one that answers it
  assign hit = busy & (wait_cnt == CNT_W'(RAM_LATENCY - 1));

  // a master may start the next request right after the pulse, so the count restarts
  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
    end else if (hit) begin
      wait_cnt <= '0;
    end else if (busy) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign bus.r_ready = hit & bus.r_valid;
  assign bus.r_last  = hit & bus.r_valid;
  assign bus.w_ready = hit & bus.w_valid;
  assign bus.w_last  = hit & bus.w_valid;

  assign r_idx = bus.r_addr[IDX_W+2:3];
  assign w_idx = bus.w_addr[IDX_W+2:3];

  assign bus.r_data = bus.r_ready ? mem[r_idx] : '0;

  always @(posedge clk) begin
    if (bus.w_ready) begin
      for (int b = 0; b < BUS_STRB_W; b++) begin
        if (bus.w_strb[b]) begin
          mem[w_idx][b*8 +: 8] <= bus.w_data[b*8 +: 8];
        end
      end
    end
  end

  a_one_channel: assert property (@(posedge clk) disable iff (reset)
    !(bus.r_valid && bus.w_valid))
    else $error("read and write requested in the same cycle");

endmodule

// ==== hw/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top
  import lsu_pkg::*, bus_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int RAM_LATENCY = 3
) (
  input  logic     clk,
  input  logic     reset,
  input  lsu_op_e  op_i,
  input  funct3_t  funct3_i,
  input  xlen_t    src1_i,
  input  xlen_t    src2_i,
  input  xlen_t    imm_i,
  input  reg_idx_t rd_i,
  output logic     stall_o,
  output logic     rd_wen_o,
  output reg_idx_t rd_o,
  output xlen_t    rd_data_o
);

  logic       done;
  reg_idx_t   done_rd;
  funct3_t    done_funct3;
  logic [2:0] done_lane;
  bus_data_t  done_rdata;
  logic       done_load;

  mem_req_if req_if ();
  mem_bus_if bus_if ();

  lsu_issue u_issue (
    .clk      (clk),
    .reset    (reset),
    .op_i     (op_i),
    .funct3_i (funct3_i),
    .src1_i   (src1_i),
    .src2_i   (src2_i),
    .imm_i    (imm_i),
    .rd_i     (rd_i),
    .stall_o  (stall_o),
    .req      (req_if.issue)
  );

  lsu_access u_access (
    .clk           (clk),
    .reset         (reset),
    .req           (req_if.access),
    .bus           (bus_if.master),
    .done_o        (done),
    .done_rd_o     (done_rd),
    .done_funct3_o (done_funct3),
    .done_lane_o   (done_lane),
    .done_rdata_o  (done_rdata),
    .done_load_o   (done_load)
  );

  lsu_align u_align (
    .clk       (clk),
    .reset     (reset),
    .done_i    (done),
    .rd_i      (done_rd),
    .funct3_i  (done_funct3),
    .lane_i    (done_lane),
    .rdata_i   (done_rdata),
    .load_i    (done_load),
    .rd_wen_o  (rd_wen_o),
    .rd_o      (rd_o),
    .rd_data_o (rd_data_o)
  );

  data_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_ram (
    .clk   (clk),
    .reset (reset),
    .bus   (bus_if.slave)
  );

endmodule

// ==== sim/clk_gen.sv ====
`timescale 1ns/10ps

module clk_gen #(
  parameter real PERIOD = 4.0
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2.0) clk_o = ~clk_o;
  end

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/10ps

module lsu_tb
  import lsu_pkg::*;
();

  localparam int RAM_WORDS    = 256;
  localparam int RAM_LATENCY  = 3;
  localparam int LOAD_LATENCY = 2 + RAM_LATENCY;
  localparam int MODEL_BYTES  = RAM_WORDS * 8;
  localparam int WAIT_LIMIT   = 50;
  localparam int NUM_RANDOM   = 200;
  localparam int DRIVE_DELAY  = 1;

  logic     clk;
  logic     reset;
  lsu_op_e  op;
  funct3_t  funct3;
  xlen_t    src1;
  xlen_t    src2;
  xlen_t    imm;
  reg_idx_t rd;
  logic     stall;
  logic     rd_wen;
  reg_idx_t rd_idx;
  xlen_t    rd_data;

  // little endian byte image of the RAM and the loads still in flight
  logic [7:0] mem_model [MODEL_BYTES];
  reg_idx_t   exp_rd [$];
  xlen_t      exp_data [$];
  integer     seed;

  clk_gen #(.PERIOD(4.0)) u_clk (.clk_o(clk));

  lsu_top #(
    .RAM_WORDS   (RAM_WORDS),
    .RAM_LATENCY (RAM_LATENCY)
  ) UUT (
    .clk       (clk),
    .reset     (reset),
    .op_i      (op),
    .funct3_i  (funct3),
    .src1_i    (src1),
    .src2_i    (src2),
    .imm_i     (imm),
    .rd_i      (rd),
    .stall_o   (stall),
    .rd_wen_o  (rd_wen),
    .rd_o      (rd_idx),
    .rd_data_o (rd_data)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      stop_on_error($sformatf("mismatch %s: got %h, expected %h", name, actual, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic wait_not_stalled();
    int waited;
    waited = 0;
    while (stall) begin
      if (waited >= WAIT_LIMIT) begin
        stop_on_error("timed out waiting for stall_o to go low");
      end
      next_cycle();
      waited++;
    end
  endtask

  function automatic int size_bytes(input funct3_t f3);
    return 1 << f3[1:0];
  endfunction

  task automatic model_store(input xlen_t addr, input funct3_t f3, input xlen_t data);
    int base;
    base = int'(addr % MODEL_BYTES);
    for (int i = 0; i < size_bytes(f3); i++) begin
      mem_model[(base + i) % MODEL_BYTES] = data[8*i +: 8];
    end
  endtask

  // funct3 bit 2 marks the unsigned loads
  function automatic xlen_t model_load(input xlen_t addr, input funct3_t f3);
    int    base;
    int    nbytes;
    xlen_t value;
    base   = int'(addr % MODEL_BYTES);
    nbytes = size_bytes(f3);
    value  = '0;
    for (int i = 0; i < nbytes; i++) begin
      value[8*i +: 8] = mem_model[(base + i) % MODEL_BYTES];
    end
    if (!f3[2]) begin
      for (int i = nbytes * 8; i < 64; i++) begin
        value[i] = value[nbytes*8-1];
      end
    end
    return value;
  endfunction

  // runs one operation at an idle pipeline and checks the exact load timing
  task automatic run_single(input lsu_op_e op_v, input funct3_t f3, input xlen_t s1,
                            input xlen_t s2, input xlen_t im, input reg_idx_t rd_v,
                            input xlen_t expected);
    int cycles;
    wait_not_stalled();
    op     = op_v;
    funct3 = f3;
    src1   = s1;
    src2   = s2;
    imm    = im;
    rd     = rd_v;
    if (op_v == LSU_STORE) begin
      model_store(s1 + im, f3, s2);
    end
    next_cycle();
    op = LSU_NONE;
    if (op_v == LSU_LOAD) begin
      next_cycle();
      cycles = 1;
      while (!rd_wen) begin
        if (cycles >= WAIT_LIMIT) begin
          stop_on_error("timed out waiting for rd_wen_o after a load");
        end
        next_cycle();
        cycles++;
      end
      check_value("rd_wen_o latency", cycles, LOAD_LATENCY);
      check_value("rd_o", rd_idx, rd_v);
      check_value("rd_data_o", rd_data, expected);
      next_cycle();
      check_value("rd_wen_o", rd_wen, 1'b0);
    end else begin
      repeat (LOAD_LATENCY + 1) begin
        next_cycle();
        check_value("rd_wen_o", rd_wen, 1'b0);
      end
    end
  endtask

  // picks an aligned address and a random base, so imm makes up the difference
  task automatic drive_random_op();
    logic [31:0] r;
    funct3_t     f3;
    xlen_t       addr;
    xlen_t       base;
    xlen_t       data;
    r = $random(seed);
    if (r[0]) begin
      f3 = r[3:1];
      if (f3 == 3'b111) begin
        f3 = 3'b011;
      end
    end else begin
      f3 = {1'b0, r[2:1]};
    end
    addr   = xlen_t'($unsigned($random(seed)) % MODEL_BYTES);
    addr   = addr & ~xlen_t'(size_bytes(f3) - 1);
    base   = {$random(seed), $random(seed)};
    data   = {$random(seed), $random(seed)};
    op     = r[0] ? LSU_LOAD : LSU_STORE;
    funct3 = f3;
    src1   = base;
    src2   = data;
    imm    = addr - base;
    rd     = r[8:4];
    if (r[0]) begin
      exp_rd.push_back(r[8:4]);
      exp_data.push_back(model_load(addr, f3));
    end else begin
      model_store(addr, f3, data);
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          num_tests;
    int          issued;
    int          guard;
    string       line;
    logic [63:0] f_op;
    logic [63:0] f_f3;
    logic [63:0] f_src1;
    logic [63:0] f_src2;
    logic [63:0] f_imm;
    logic [63:0] f_rd;
    logic [63:0] f_exp;

    seed   = 13467;
    reset  = 1'b1;
    op     = LSU_NONE;
    funct3 = '0;
    src1   = '0;
    src2   = '0;
    imm    = '0;
    rd     = '0;
    for (int i = 0; i < MODEL_BYTES; i++) begin
      mem_model[i] = 8'h00;
    end

    repeat (3) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    next_cycle();
    check_value("stall_o", stall, 1'b0);
    check_value("rd_wen_o", rd_wen, 1'b0);

    fd = $fopen("sim/lsu_tests.txt", "r");
    if (fd == 0) begin
      stop_on_error("could not open sim/lsu_tests.txt");
    end
    num_tests = 0;
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %h %h %h",
                  f_op, f_f3, f_src1, f_src2, f_imm, f_rd, f_exp);
      if (n == 7) begin
        run_single(lsu_op_e'(f_op[1:0]), funct3_t'(f_f3[2:0]), f_src1, f_src2, f_imm,
                   reg_idx_t'(f_rd[4:0]), f_exp);
        num_tests++;
      end
    end
    $fclose(fd);
    if (num_tests == 0) begin
      stop_on_error("no operations found in sim/lsu_tests.txt");
    end

    // in the back to back phase a new operation goes in whenever stall_o is low
    issued = 0;
    guard  = 0;
    while (issued < NUM_RANDOM || op != LSU_NONE || exp_data.size() != 0) begin
      if (rd_wen) begin
        if (exp_data.size() == 0) begin
          stop_on_error("rd_wen_o pulsed with no load outstanding");
        end
        check_value("rd_o", rd_idx, exp_rd.pop_front());
        check_value("rd_data_o", rd_data, exp_data.pop_front());
      end
      if (!stall) begin
        if (issued < NUM_RANDOM) begin
          drive_random_op();
          issued++;
        end else begin
          op = LSU_NONE;
        end
      end
      if (guard >= NUM_RANDOM * (LOAD_LATENCY + 2)) begin
        stop_on_error("timed out waiting for the random operations to complete");
      end
      next_cycle();
      guard++;
    end

    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== project.f ====
hw/lsu_pkg.sv
hw/bus_pkg.sv
hw/mem_req_if.sv
hw/mem_bus_if.sv
hw/lsu_issue.sv
hw/lsu_access.sv
hw/lsu_align.sv
hw/data_ram.sv
hw/lsu_top.sv
sim/clk_gen.sv
sim/lsu_tb.sv

// ==== sim/lsu_tests.txt ====
# op funct3 src1 src2 imm rd expected, all fields hex
# op 1 is a load and 2 a store, stores carry a zero expected value
2 3 0000000000000100 0123456789abcdef 0000000000000008 00 0000000000000000
1 3 0000000000000110 0000000000000000 fffffffffffffff8 05 0123456789abcdef
2 3 0000000000000200 89abcdef8421f0a5 0000000000000000 00 0000000000000000
1 0 00000000000001f0 0000000000000000 0000000000000010 01 ffffffffffffffa5
1 4 00000000000001f0 0000000000000000 0000000000000010 02 00000000000000a5
1 0 0000000000000202 0000000000000000 0000000000000000 0c 0000000000000021
1 1 0000000000000200 0000000000000000 0000000000000002 03 ffffffffffff8421
1 5 0000000000000200 0000000000000000 0000000000000002 04 0000000000008421
1 2 0000000000000204 0000000000000000 0000000000000000 06 ffffffff89abcdef
1 6 0000000000000204 0000000000000000 0000000000000000 07 0000000089abcdef
2 3 0000000000000300 1111111111111111 0000000000000000 00 0000000000000000
2 0 0000000000000300 ffffffffffffffaa 0000000000000001 00 0000000000000000
2 1 0000000000000300 000012345678bbcc 0000000000000006 00 0000000000000000
2 0 0000000000000304 000000000000005d 0000000000000000 00 0000000000000000
2 1 0000000000000300 0000000000007e80 0000000000000002 00 0000000000000000
1 3 0000000000000300 0000000000000000 0000000000000000 08 bbcc115d7e80aa11
1 1 0000000000000302 0000000000000000 0000000000000000 09 0000000000007e80
2 2 0000000000000308 00000000deadbeef 0000000000000000 00 0000000000000000
1 2 0000000000000300 0000000000000000 0000000000000008 0a ffffffffdeadbeef
1 6 0000000000000308 0000000000000000 0000000000000000 0b 00000000deadbeef
